//--- atsTimerTop.f
+incdir+include
source/atsPkg.sv
source/ctrlPortRx.sv
source/instArbiter.sv
source/clockBank.sv
source/alarmBank.sv
source/atsTimerTop.sv
verif/atsTimerTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the ATS timer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f atsTimerTop.f \
  --top-module atsTimerTb -o atsTimerSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/atsTimerSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx '\*\* PASS \*\*' "$LOG"; then
  exit 0
fi
echo "simulation did not report a pass, see $LOG"
exit 1

//--- include/atsModel.svh
/*
 * ATS timer reference model
 * cycle stepped receivers, arbiter, clocks and alarms, predicts stat and data
 */
`ifndef ATS_MODEL_SVH
`define ATS_MODEL_SVH

logic [1:0]                   mWait, mValid;   // per client receiver
logic [15:0]                  mFirst [2];
atsPkg::atsInstr_u            mWord  [2];
logic [1:0]                   mDiv;
logic [atsPkg::NUM_CLOCKS-1:0] mEn;
logic [1:0]                   mRate [atsPkg::NUM_CLOCKS];
logic [15:0]                  mCnt  [atsPkg::NUM_CLOCKS];
logic [atsPkg::NUM_ALARMS-1:0] aEn, aRep;
logic [3:0]                   aClk   [atsPkg::NUM_ALARMS];
logic [15:0]                  aVal   [atsPkg::NUM_ALARMS];
logic [1:0]                   aPulse [atsPkg::NUM_ALARMS];
atsPkg::statPair_t            mStat;   // predicted outputs
atsPkg::alarmMask_t           mData;

task automatic modelReset();
  {mWait, mValid, mDiv, mEn, aEn, aRep, mStat, mData} = '0;
  for (int i = 0; i < atsPkg::NUM_CLOCKS; i++) begin
    mRate[i] = '0;
    mCnt[i]  = '0;
  end
  for (int i = 0; i < atsPkg::NUM_ALARMS; i++) begin
    aClk[i]   = '0;
    aVal[i]   = '0;
    aPulse[i] = '0;
  end
endtask

// one clk_1x edge, inputs as sampled at that edge
task automatic modelStep(input logic req, input logic [15:0] a, input logic [15:0] b);
  logic [1:0]                    take, isClk, isAlm;
  logic [atsPkg::NUM_CLOCKS-1:0] tk;
  logic [atsPkg::NUM_ALARMS-1:0] hit;
  logic [15:0]                   half [2];
  logic [15:0]                   nc;
  int                            id;
  half[0] = a;
  half[1] = b;
  // arbiter on held words
  for (int p = 0; p < 2; p++) begin
    isClk[p] = mValid[p] && (mWord[p].clkView.opcode inside {3'b001, 3'b010});
    isAlm[p] = mValid[p] && (mWord[p].almView.opcode inside {3'b101, 3'b110, 3'b111});
    take[p]  = (isClk[p] && (mWord[p].clkView.opcode == 3'b010 || mWord[p].clkView.ctl != 2'b11))
            || (isAlm[p] && mWord[p].almView.alarmId < atsPkg::NUM_ALARMS);
  end
  if ((isClk[0] && isClk[1] && mWord[0].clkView.clockId == mWord[1].clkView.clockId) ||
      (isAlm[0] && isAlm[1] && mWord[0].almView.alarmId == mWord[1].almView.alarmId)) begin
    take = 2'b00;
  end
  // ticks and matches on old state
  for (int i = 0; i < atsPkg::NUM_CLOCKS; i++) begin
    tk[i] = mEn[i] && (mRate[i] == 2'b00 || (mRate[i] == 2'b01 && mDiv[0]) ||
                       (mRate[i] == 2'b10 && mDiv == 2'd3));
  end
  hit = '0;
  for (int p = 0; p < 2; p++) begin
    if (take[p] && isAlm[p]) hit[mWord[p].almView.alarmId] = 1'b1;
  end
  for (int i = 0; i < atsPkg::NUM_ALARMS; i++) begin
    nc = mCnt[aClk[i]] + 1'b1;
    if (aEn[i] && tk[aClk[i]] && nc == aVal[i] && !hit[i]) begin
      aPulse[i] = 2'd2;
      if (!aRep[i]) aEn[i] = 1'b0;
    end else if (aPulse[i] != 2'd0) begin
      aPulse[i] = aPulse[i] - 2'd1;
    end
  end
  // alarm writes see the pre-edge counts
  for (int p = 0; p < 2; p++) begin
    id = mWord[p].almView.alarmId;
    if (take[p] && isAlm[p] && mWord[p].almView.opcode == 3'b111) begin
      aEn[id] = mWord[p].almView.flag;
    end else if (take[p] && isAlm[p]) begin
      aEn[id]  = 1'b1;
      aClk[id] = mWord[p].almView.clockId;
      aRep[id] = mWord[p].almView.flag && mWord[p].almView.opcode == 3'b101;
      aVal[id] = mWord[p].almView.value +
                 ((mWord[p].almView.opcode == 3'b110) ? mCnt[aClk[id]] : 16'd0);
    end
  end
  for (int i = 0; i < atsPkg::NUM_CLOCKS; i++) begin
    if (tk[i]) mCnt[i] = mCnt[i] + 1'b1;
  end
  for (int p = 0; p < 2; p++) begin
    id = mWord[p].clkView.clockId;
    if (take[p] && isClk[p] && mWord[p].clkView.opcode == 3'b001) begin
      mCnt[id]  = mWord[p].clkView.count;
      mRate[id] = mWord[p].clkView.ctl;
      mEn[id]   = 1'b1;
    end else if (take[p] && isClk[p]) begin
      mEn[id] = mWord[p].clkView.ctl[1];
    end
  end
  // receivers
  for (int p = 0; p < 2; p++) begin
    mValid[p] = mWait[p] && req;
    if (mWait[p]) mWord[p] = {mFirst[p], half[p]};
    else if (req) mFirst[p] = half[p];
    mWait[p] = !mWait[p] && req && (half[p][15:13] != 3'b000);
  end
  mDiv  = mDiv + 2'd1;
  mStat = take;
  for (int i = 0; i < atsPkg::NUM_ALARMS; i++) mData[i] = aPulse[i] != 2'd0;
endtask

`endif

//--- verif/atsTimerTb.sv
/*
 * ATS timer testbench
 * directed alarm and timer cases, then seeded random instruction pairs,
 * all checked cycle by cycle against the reference model
 */
`timescale 1ns/1ps
`default_nettype none

module atsTimerTb;

  localparam int RAND_TXN = 300;
  localparam int DIR_TXN  = 19;
  localparam int TIMEOUT  = (RAND_TXN + DIR_TXN) * 8 + 200;  // in cycles

  logic                      clk_1x = 1'b0;
  logic                      reset;
  logic                      req;
  logic [atsPkg::HALF_W-1:0] ctrlA, ctrlB;
  atsPkg::statPair_t         stat;
  atsPkg::alarmMask_t        data;

  int statErrors, dataErrors, otherErrors;
  int ackCount, fireCycles, cycles;

  `include "atsModel.svh"

  atsTimerTop DUT (.clk_1x, .reset, .req, .ctrlA, .ctrlB, .stat, .data);

  always #5 clk_1x = ~clk_1x;  // 10 ns period

  ////////////////////
  // compare tasks
  task automatic checkStat(input atsPkg::statPair_t exp, input atsPkg::statPair_t got);
    if (got !== exp) begin
      statErrors++;
      $display("CHECK FAILED at %0t: stat is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic checkData(input atsPkg::alarmMask_t exp, input atsPkg::alarmMask_t got);
    if (got !== exp) begin
      dataErrors++;
      $display("CHECK FAILED at %0t: data is %h, expected %h", $time, got, exp);
    end
  endtask

  ////////////////////
  // instruction builders
  function automatic atsPkg::atsInstr_u clkInstr(input logic [2:0] op, input logic [3:0] id,
                                                 input logic [1:0] ctl, input logic [15:0] cnt);
    atsPkg::atsInstr_u w;
    w                 = '0;
    w.clkView.opcode  = op;
    w.clkView.clockId = id;
    w.clkView.ctl     = ctl;  // rate, or enable in bit 1
    w.clkView.count   = cnt;
    return w;
  endfunction

  function automatic atsPkg::atsInstr_u almInstr(input logic [2:0] op, input logic [4:0] id,
                                                 input logic flag, input logic [3:0] clkId,
                                                 input logic [15:0] val);
    atsPkg::atsInstr_u w;
    w                 = '0;
    w.almView.opcode  = op;
    w.almView.alarmId = id;
    w.almView.flag    = flag;
    w.almView.clockId = clkId;
    w.almView.value   = val;
    return w;
  endfunction

  // biased to few ids so the two clients collide
  function automatic atsPkg::atsInstr_u randInstr();
    logic [2:0] op;
    logic [4:0] aid;
    op  = $urandom % 8;
    aid = ($urandom % 4 == 0) ? 5'($urandom % 32) : 5'($urandom % 4);
    if (op inside {3'b001, 3'b010, 3'b011}) begin
      return clkInstr(op, 4'($urandom % 4), 2'($urandom % 4), 16'($urandom % 32));
    end
    return almInstr(op, aid, 1'($urandom % 2), 4'($urandom % 4), 16'($urandom % 40));
  endfunction

  ////////////////////
  // stimulus, one cycle per call, 1 ns after the edge
  task automatic driveCycle(input logic r, input logic [15:0] a, input logic [15:0] b);
    @(posedge clk_1x);
    #1;
    req   = r;
    ctrlA = a;
    ctrlB = b;
  endtask

  task automatic sendPair(input atsPkg::atsInstr_u a, input atsPkg::atsInstr_u b,
                          input logic keepReq);
    logic [31:0] wa, wb;
    wa = a;
    wb = b;
    driveCycle(1'b1, wa[31:16], wb[31:16]);
    driveCycle(keepReq, wa[15:0], wb[15:0]);  // req low here loses the word
  endtask

  task automatic idle(input int n);
    repeat (n) driveCycle(1'b0, 16'h0, 16'h0);
  endtask

  task automatic applyReset();
    @(posedge clk_1x);
    #1;
    reset = 1'b1;
    req   = 1'b0;
    repeat (8) @(posedge clk_1x);
    #1;
    reset = 1'b0;
  endtask

  ////////////////////
  // model step at the edge, compare half a cycle later
  always @(posedge clk_1x) begin
    if (reset) modelReset();
    else modelStep(req, ctrlA, ctrlB);
  end

  always @(negedge clk_1x) begin
    if (reset) modelReset();  // async clear already visible
    checkStat(mStat, stat);
    checkData(mData, data);
    if (stat != 2'b00) ackCount++;
    if (data != '0) fireCycles++;
  end

  always @(posedge clk_1x) begin
    cycles++;
    if (cycles > TIMEOUT) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    atsPkg::atsInstr_u nop;
    void'($urandom(92));
    nop   = '0;
    reset = 1'b1;
    req   = 1'b0;
    ctrlA = '0;
    ctrlB = '0;
    repeat (8) @(posedge clk_1x);
    #1;
    reset = 1'b0;

    // one-shot on a 1x clock, no refire after reload
    sendPair(clkInstr(atsPkg::OP_SET_CLK, 0, atsPkg::RATE_1X, 100), nop, 1'b1);
    sendPair(nop, almInstr(atsPkg::OP_SET_ALM, 0, 1'b0, 0, 112), 1'b1);
    idle(15);
    sendPair(clkInstr(atsPkg::OP_SET_CLK, 0, atsPkg::RATE_1X, 100), nop, 1'b1);
    idle(20);
    // repeating alarm fires again after reload
    sendPair(clkInstr(atsPkg::OP_SET_CLK, 1, atsPkg::RATE_1X, 50),
             almInstr(atsPkg::OP_SET_ALM, 1, 1'b1, 1, 58), 1'b1);
    idle(12);
    sendPair(clkInstr(atsPkg::OP_SET_CLK, 1, atsPkg::RATE_1X, 50), nop, 1'b1);
    idle(12);
    // timers on the 2x and 4x clocks
    sendPair(clkInstr(atsPkg::OP_SET_CLK, 2, atsPkg::RATE_2X, 0),
             clkInstr(atsPkg::OP_SET_CLK, 3, atsPkg::RATE_4X, 0), 1'b1);
    sendPair(almInstr(atsPkg::OP_SET_TMR, 2, 1'b0, 2, 5),
             almInstr(atsPkg::OP_SET_TMR, 3, 1'b0, 3, 3), 1'b1);
    idle(25);
    // clock disabled, alarm stays silent
    sendPair(clkInstr(atsPkg::OP_SET_CLK, 4, atsPkg::RATE_1X, 0),
             almInstr(atsPkg::OP_SET_ALM, 4, 1'b0, 4, 12), 1'b1);
    sendPair(clkInstr(atsPkg::OP_EN_CLK, 4, 2'b00, 0), nop, 1'b1);
    idle(20);
    // alarm off, then on again
    sendPair(clkInstr(atsPkg::OP_SET_CLK, 5, atsPkg::RATE_1X, 0),
             almInstr(atsPkg::OP_SET_ALM, 5, 1'b0, 5, 14), 1'b1);
    sendPair(nop, almInstr(atsPkg::OP_EN_ALM, 5, 1'b0, 0, 0), 1'b1);
    idle(16);
    sendPair(clkInstr(atsPkg::OP_SET_CLK, 5, atsPkg::RATE_1X, 0),
             almInstr(atsPkg::OP_EN_ALM, 5, 1'b1, 0, 0), 1'b1);
    idle(20);
    // refused: opcode 011, slot 30, rate 3, two conflicts
    sendPair(clkInstr(3'b011, 6, 0, 0), almInstr(atsPkg::OP_SET_ALM, 30, 1'b0, 0, 5), 1'b1);
    sendPair(clkInstr(atsPkg::OP_SET_CLK, 6, 2'b11, 0), nop, 1'b1);
    sendPair(clkInstr(atsPkg::OP_SET_CLK, 7, 0, 0),
             clkInstr(atsPkg::OP_EN_CLK, 7, 2'b10, 0), 1'b1);
    sendPair(almInstr(atsPkg::OP_SET_ALM, 8, 1'b0, 0, 9),
             almInstr(atsPkg::OP_EN_ALM, 8, 1'b1, 0, 0), 1'b1);
    // reset lands on an ack and on the slot 10 finish pulse
    sendPair(clkInstr(atsPkg::OP_SET_CLK, 8, atsPkg::RATE_1X, 0),
             almInstr(atsPkg::OP_SET_ALM, 10, 1'b0, 8, 4), 1'b1);
    idle(2);
    sendPair(nop, almInstr(atsPkg::OP_SET_ALM, 9, 1'b0, 8, 20), 1'b1);
    idle(1);
    applyReset();
    // clock 8 restarts from zero so a kept slot 9 would fire
    sendPair(clkInstr(atsPkg::OP_EN_CLK, 8, 2'b10, 0), nop, 1'b1);
    idle(30);

    ////////////////////
    // random pairs, new pair every 2 to 6 cycles
    for (int t = 0; t < RAND_TXN; t++) begin
      sendPair(randInstr(), randInstr(), ($urandom % 8) != 0);
      idle($urandom % 5);
    end
    idle(20);

    if (ackCount == 0 || fireCycles == 0) begin
      otherErrors++;
      $display("no ack or no alarm was seen during the whole run");
    end
    $display("errors: stat %0d, data %0d, other %0d", statErrors, dataErrors, otherErrors);
    if (statErrors + dataErrors + otherErrors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/atsTimerTop.sv
/*
 * ATS timer top
 * two control receivers, arbiter, clock bank and alarm bank
 */
`timescale 1ns/1ps
`default_nettype none

module atsTimerTop (
  input  logic                      clk_1x,
  input  logic                      reset,
  input  logic                      req,
  input  logic [atsPkg::HALF_W-1:0] ctrlA,
  input  logic [atsPkg::HALF_W-1:0] ctrlB,
  output atsPkg::statPair_t         stat,
  output atsPkg::alarmMask_t        data
);

  atsPkg::atsInstr_u             wordA, wordB;    // assembled words
  logic                          validA, validB;
  logic                          clkWrA, clkWrB;
  logic                          almWrA, almWrB;
  atsPkg::atsInstr_u             clkOpA, clkOpB;
  atsPkg::atsInstr_u             almOpA, almOpB;
  atsPkg::countVec_t             counts;
  logic [atsPkg::NUM_CLOCKS-1:0] tick;

  ////////////////////
  // client ports
  ctrlPortRx rxA (
    .clk_1x, .reset, .req,
    .half      (ctrlA),
    .word      (wordA),
    .wordValid (validA)
  );

  ctrlPortRx rxB (
    .clk_1x, .reset, .req,
    .half      (ctrlB),
    .word      (wordB),
    .wordValid (validB)
  );

  instArbiter arbiter (
    .clk_1x, .reset,
    .wordA, .wordB, .validA, .validB,
    .clkWrA, .clkWrB, .almWrA, .almWrB,
    .clkOpA, .clkOpB, .almOpA, .almOpB,
    .stat
  );

  ////////////////////
  // register file
  clockBank clocks (
    .clk_1x, .reset,
    .clkWrA, .clkWrB, .clkOpA, .clkOpB,
    .counts, .tick
  );

  alarmBank alarms (
    .clk_1x, .reset,
    .almWrA, .almWrB, .almOpA, .almOpB,
    .counts, .tick,
    .data
  );

endmodule

`default_nettype wire

//--- source/alarmBank.sv
/*
 * alarm bank
 * 24 alarm and timer slots, match on the post tick count, two cycle finish
 */
`timescale 1ns/1ps
`default_nettype none

module alarmBank (
  input  logic                          clk_1x,
  input  logic                          reset,
  input  logic                          almWrA,
  input  logic                          almWrB,
  input  atsPkg::atsInstr_u             almOpA,
  input  atsPkg::atsInstr_u             almOpB,
  input  atsPkg::countVec_t             counts,
  input  logic [atsPkg::NUM_CLOCKS-1:0] tick,
  output atsPkg::alarmMask_t            data
);

  logic [atsPkg::NUM_ALARMS-1:0] enable;
  logic [atsPkg::NUM_ALARMS-1:0] repeatMode;  // clear for one-shot and timer
  logic [atsPkg::NUM_ALARMS-1:0] writeHit;    // slot written this edge
  logic [atsPkg::NUM_ALARMS-1:0] fire;
  logic [atsPkg::CLK_ID_W-1:0]   clkSel    [atsPkg::NUM_ALARMS];
  logic [atsPkg::COUNT_W-1:0]    value     [atsPkg::NUM_ALARMS];
  logic [atsPkg::COUNT_W-1:0]    nextCount [atsPkg::NUM_ALARMS];
  logic [1:0]                    pulse     [atsPkg::NUM_ALARMS];  // finish stretch
  logic [1:0]                    wr;
  atsPkg::atsInstr_u             op [2];

  assign wr    = {almWrB, almWrA};
  assign op[0] = almOpA;
  assign op[1] = almOpB;

  ////////////////////
  // match
  always_comb begin
    for (int i = 0; i < atsPkg::NUM_ALARMS; i++) begin
      writeHit[i]  = (wr[0] && (int'(op[0].almView.alarmId) == i)) ||
                     (wr[1] && (int'(op[1].almView.alarmId) == i));
      nextCount[i] = counts[clkSel[i]] + 1'b1;  // count after this tick
      // a write to the slot suppresses the match
      fire[i]      = enable[i] && tick[clkSel[i]] && (nextCount[i] == value[i]) &&
                     !writeHit[i];
      data[i]      = pulse[i] != 2'd0;
    end
  end

  ////////////////////
  // slot state
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      enable     <= '0;
      repeatMode <= '0;
      for (int i = 0; i < atsPkg::NUM_ALARMS; i++) begin
        clkSel[i] <= '0;
        value[i]  <= '0;
        pulse[i]  <= '0;
      end
    end else begin
      for (int i = 0; i < atsPkg::NUM_ALARMS; i++) begin
        if (fire[i]) begin
          pulse[i] <= 2'd2;
          if (!repeatMode[i]) begin
            enable[i] <= 1'b0;  // one-shot and timer retire
          end
        end else if (pulse[i] != 2'd0) begin
          pulse[i] <= pulse[i] - 2'd1;
        end
      end
      for (int p = 0; p < 2; p++) begin
        if (wr[p]) begin
          if (op[p].almView.opcode == atsPkg::OP_EN_ALM) begin
            enable[op[p].almView.alarmId] <= op[p].almView.flag;
          end else begin
            enable[op[p].almView.alarmId]     <= 1'b1;
            clkSel[op[p].almView.alarmId]     <= op[p].almView.clockId;
            repeatMode[op[p].almView.alarmId] <= op[p].almView.flag &&
                                                 (op[p].almView.opcode == atsPkg::OP_SET_ALM);
            // timer expires interval counts from now
            value[op[p].almView.alarmId] <= (op[p].almView.opcode == atsPkg::OP_SET_TMR) ?
                op[p].almView.value + counts[op[p].almView.clockId] : op[p].almView.value;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/clockBank.sv
/*
 * clock bank
 * tick divider plus 16 counters, each at 1x, 2x or 4x of clk_1x
 */
`timescale 1ns/1ps
`default_nettype none

module clockBank (
  input  logic                          clk_1x,
  input  logic                          reset,
  input  logic                          clkWrA,
  input  logic                          clkWrB,
  input  atsPkg::atsInstr_u             clkOpA,
  input  atsPkg::atsInstr_u             clkOpB,
  output atsPkg::countVec_t             counts,
  output logic [atsPkg::NUM_CLOCKS-1:0] tick
);

  logic [1:0]                          divider;  // free running phase
  logic [atsPkg::NUM_CLOCKS-1:0]       enable;
  logic [atsPkg::NUM_CLOCKS-1:0][1:0]  rate;
  logic [1:0]                          wr;       // write strobe per port
  atsPkg::atsInstr_u                   op [2];

  assign wr    = {clkWrB, clkWrA};
  assign op[0] = clkOpA;
  assign op[1] = clkOpB;

  // tick enables, clock enable and rate phase
  always_comb begin
    for (int i = 0; i < atsPkg::NUM_CLOCKS; i++) begin
      case (rate[i])
        atsPkg::RATE_1X: tick[i] = enable[i];
        atsPkg::RATE_2X: tick[i] = enable[i] && divider[0];
        atsPkg::RATE_4X: tick[i] = enable[i] && (divider == 2'd3);
        default:         tick[i] = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      divider <= '0;
      enable  <= '0;
      rate    <= '0;
      counts  <= '0;
    end else begin
      divider <= divider + 2'd1;
      for (int i = 0; i < atsPkg::NUM_CLOCKS; i++) begin
        if (tick[i]) begin
          counts[i] <= counts[i] + 1'b1;  // wraps
        end
      end
      // writes last, a load beats the increment
      for (int p = 0; p < 2; p++) begin
        if (wr[p]) begin
          if (op[p].clkView.opcode == atsPkg::OP_SET_CLK) begin
            counts[op[p].clkView.clockId] <= op[p].clkView.count;
            rate[op[p].clkView.clockId]   <= op[p].clkView.ctl;
            enable[op[p].clkView.clockId] <= 1'b1;  // set also starts it
          end else begin
            enable[op[p].clkView.clockId] <= op[p].clkView.ctl[1];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/instArbiter.sv
/*
 * instruction arbiter
 * checks both client words, refuses conflicts, drives bank writes and status
 */
`timescale 1ns/1ps
`default_nettype none

module instArbiter (
  input  logic              clk_1x,
  input  logic              reset,
  input  atsPkg::atsInstr_u wordA,
  input  atsPkg::atsInstr_u wordB,
  input  logic              validA,
  input  logic              validB,
  output logic              clkWrA,
  output logic              clkWrB,
  output logic              almWrA,
  output logic              almWrB,
  output atsPkg::atsInstr_u clkOpA,
  output atsPkg::atsInstr_u clkOpB,
  output atsPkg::atsInstr_u almOpA,
  output atsPkg::atsInstr_u almOpB,
  output atsPkg::statPair_t stat
);

  function automatic logic isClk(input logic [2:0] opcode);
    return opcode inside {atsPkg::OP_SET_CLK, atsPkg::OP_EN_CLK};
  endfunction

  function automatic logic isAlm(input logic [2:0] opcode);
    return opcode inside {atsPkg::OP_SET_ALM, atsPkg::OP_SET_TMR, atsPkg::OP_EN_ALM};
  endfunction

  // opcode kept, index in range, rate legal
  function automatic logic legal(input atsPkg::atsInstr_u w);
    logic ok;
    ok = 1'b0;
    if (isClk(w.clkView.opcode)) begin
      ok = (w.clkView.opcode == atsPkg::OP_EN_CLK) ||
           (w.clkView.ctl inside {atsPkg::RATE_1X, atsPkg::RATE_2X, atsPkg::RATE_4X});
    end else if (isAlm(w.almView.opcode)) begin
      ok = w.almView.alarmId < atsPkg::NUM_ALARMS;  // slots 24..31 do not exist
    end
    return ok;
  endfunction

  logic clsClkA, clsClkB;  // valid clock instruction
  logic clsAlmA, clsAlmB;  // valid alarm instruction
  logic conflict;
  logic takeA, takeB;

  ////////////////////
  // decode and conflict check
  assign clsClkA = validA && isClk(wordA.clkView.opcode);
  assign clsClkB = validB && isClk(wordB.clkView.opcode);
  assign clsAlmA = validA && isAlm(wordA.almView.opcode);
  assign clsAlmB = validB && isAlm(wordB.almView.opcode);

  // same clock or same slot from both sides, nobody wins
  assign conflict = (clsClkA && clsClkB &&
                     (wordA.clkView.clockId == wordB.clkView.clockId)) ||
                    (clsAlmA && clsAlmB &&
                     (wordA.almView.alarmId == wordB.almView.alarmId));

  assign takeA = validA && legal(wordA) && !conflict;
  assign takeB = validB && legal(wordB) && !conflict;

  ////////////////////
  // bank writes, committed by the banks at the next edge
  assign clkWrA = takeA && clsClkA;
  assign clkWrB = takeB && clsClkB;
  assign almWrA = takeA && clsAlmA;
  assign almWrB = takeB && clsAlmB;

  assign clkOpA = wordA;
  assign clkOpB = wordB;
  assign almOpA = wordA;
  assign almOpB = wordB;

  // ack for one cycle, same edge as the write
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      stat <= '0;
    end else begin
      stat <= {takeB, takeA};
    end
  end

endmodule

`default_nettype wire

//--- source/ctrlPortRx.sv
/*
 * control port receiver
 * joins the two 16-bit halves of one client instruction
 */
`timescale 1ns/1ps
`default_nettype none

module ctrlPortRx (
  input  logic                      clk_1x,
  input  logic                      reset,
  input  logic                      req,
  input  logic [atsPkg::HALF_W-1:0] half,
  output atsPkg::atsInstr_u         word,
  output logic                      wordValid
);

  logic [atsPkg::HALF_W-1:0] firstHalf;  // upper half, held one cycle
  logic                      waiting;    // second half due next edge
  logic                      opcodeSeen;

  assign opcodeSeen = half[atsPkg::HALF_W-1 -: 3] != atsPkg::OP_NOP;

  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      waiting   <= 1'b0;
      wordValid <= 1'b0;
    end else begin
      wordValid <= waiting && req;                   // lost if req fell
      waiting   <= !waiting && req && opcodeSeen;    // zero opcode ignored
    end
  end

  // word payload
  always_ff @(posedge clk_1x) begin
    if (!waiting && req) begin
      firstHalf <= half;
    end
    if (waiting) begin
      word <= {firstHalf, half};  // second half appended
    end
  end

endmodule

`default_nettype wire

//--- source/atsPkg.sv
/*
 * ATS timer shared definitions
 * sizes, opcode and rate codes, the two views of an instruction word
 */
`default_nettype none

package atsPkg;

  ////////////////////
  // sizes
  localparam int NUM_CLOCKS = 16;
  localparam int NUM_ALARMS = 24;
  localparam int COUNT_W    = 16;  // clock count and alarm value
  localparam int CLK_ID_W   = 4;
  localparam int ALM_ID_W   = 5;   // 24..31 illegal
  localparam int HALF_W     = 16;  // one instruction half

  ////////////////////
  // opcodes, top three bits of the first half
  localparam logic [2:0] OP_NOP     = 3'b000;
  localparam logic [2:0] OP_SET_CLK = 3'b001;
  localparam logic [2:0] OP_EN_CLK  = 3'b010;
  localparam logic [2:0] OP_SET_ALM = 3'b101;
  localparam logic [2:0] OP_SET_TMR = 3'b110;
  localparam logic [2:0] OP_EN_ALM  = 3'b111;

  // clock rates, code 3 illegal
  localparam logic [1:0] RATE_1X = 2'b00;
  localparam logic [1:0] RATE_2X = 2'b01;
  localparam logic [1:0] RATE_4X = 2'b10;

  ////////////////////
  // clock instructions (set clock, enable clock)
  typedef struct packed {
    logic [2:0]          opcode;
    logic [CLK_ID_W-1:0] clockId;
    logic                spare0;
    logic [1:0]          ctl;      // rate, or enable in bit 1
    logic [5:0]          spare1;
    logic [COUNT_W-1:0]  count;    // load value
  } clkView_t;

  // alarm instructions (set alarm, set timer, enable alarm)
  typedef struct packed {
    logic [2:0]          opcode;
    logic [ALM_ID_W-1:0] alarmId;
    logic                flag;     // repeat or enable
    logic [2:0]          spare;
    logic [CLK_ID_W-1:0] clockId;  // clock compared against
    logic [COUNT_W-1:0]  value;    // alarm time or interval
  } almView_t;

  // one 32-bit word, opcode in the same place for both
  typedef union packed {
    clkView_t clkView;
    almView_t almView;
  } atsInstr_u;

  typedef logic [NUM_CLOCKS-1:0][COUNT_W-1:0] countVec_t;
  typedef logic [NUM_ALARMS-1:0]              alarmMask_t;  // one bit per slot
  typedef logic [1:0]                         statPair_t;   // bit0 A, bit1 B, 1 = ack

endpackage

`default_nettype wire
